//--- source/link_test_pkg.sv
//****************************************************************************
// Link test package
// Flit and link types shared by the test nodes, endpoints and FIFOs
//****************************************************************************

package link_test_pkg;

  localparam int num_channels  = 4;
  localparam int channel_width = 8;
  localparam int flit_width    = num_channels * channel_width;
  localparam int count_width   = 32;
  localparam int fifo_lg_depth = 3;

  // One flit, channel 0 in the low byte
  typedef struct packed {
    logic [num_channels-1:0][channel_width-1:0] channel;
  } flit_t;

  // One direction of the link plus ready for the reverse direction
  typedef struct packed {
    logic  valid;
    flit_t data;
    logic  ready_rev;
  } link_s;

endpackage

//--- source/two_slot_fifo.sv
//****************************************************************************
// Two slot FIFO
// Two-entry ready/valid buffer, ready driven from state only
//****************************************************************************

module two_slot_fifo
  (input  logic                  node_clk_i
  ,input  logic                  node_reset_i
  ,input  logic                  in_valid_i
  ,input  link_test_pkg::flit_t  in_data_i
  ,output logic                  in_ready_o
  ,output logic                  out_valid_o
  ,output link_test_pkg::flit_t  out_data_o
  ,input  logic                  out_ready_i
  );

  import link_test_pkg::*;

  flit_t mem_r [2];
  logic  wr_ptr_r;
  logic  rd_ptr_r;
  logic  full_r;
  logic  enq;
  logic  deq;

  assign in_ready_o  = ~full_r;
  assign out_valid_o = full_r | (wr_ptr_r != rd_ptr_r);
  assign out_data_o  = mem_r[rd_ptr_r];

  assign enq = in_valid_i & ~full_r;
  assign deq = out_valid_o & out_ready_i;

  always_ff @(posedge node_clk_i)
  begin
    if (node_reset_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= ~wr_ptr_r;
      if (deq)
        rd_ptr_r <= ~rd_ptr_r;
      // Fills only when one entry was already held
      if (enq & ~deq)
        full_r <= (wr_ptr_r != rd_ptr_r);
      else if (deq & ~enq)
        full_r <= 1'b0;
    end
  end

  always_ff @(posedge node_clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= in_data_i;
  end

endmodule

//--- source/async_link_fifo.sv
//****************************************************************************
// Async link FIFO
// Dual-clock flit FIFO with Gray pointers and two-flop synchronizers
//****************************************************************************

module async_link_fifo
  (input  logic                  wr_clk_i
  ,input  logic                  wr_reset_i
  ,input  logic                  wr_en_i
  ,input  link_test_pkg::flit_t  wr_data_i
  ,output logic                  wr_full_o
  ,input  logic                  rd_clk_i
  ,input  logic                  rd_reset_i
  ,input  logic                  rd_deq_i
  ,output link_test_pkg::flit_t  rd_data_o
  ,output logic                  rd_valid_o
  );

  import link_test_pkg::*;

  function automatic logic [fifo_lg_depth:0] bin_to_gray(input logic [fifo_lg_depth:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  logic [flit_width-1:0] mem_r [2**fifo_lg_depth];

  // Write domain
  logic [fifo_lg_depth:0] wr_bin_r;
  logic [fifo_lg_depth:0] wr_gray_r;
  logic [fifo_lg_depth:0] rd_gray_meta_r;
  logic [fifo_lg_depth:0] rd_gray_sync_r;
  logic [fifo_lg_depth:0] wr_bin_next;
  logic                   wr_push;

  // Read domain
  logic [fifo_lg_depth:0] rd_bin_r;
  logic [fifo_lg_depth:0] rd_gray_r;
  logic [fifo_lg_depth:0] wr_gray_meta_r;
  logic [fifo_lg_depth:0] wr_gray_sync_r;
  logic [fifo_lg_depth:0] rd_bin_next;
  logic                   rd_pop;

  // Full when the top two Gray bits differ and the rest match
  assign wr_full_o = (wr_gray_r == {~rd_gray_sync_r[fifo_lg_depth -: 2],
                                     rd_gray_sync_r[fifo_lg_depth-2:0]});
  assign wr_push     = wr_en_i & ~wr_full_o;
  assign wr_bin_next = wr_bin_r + 1'b1;

  always_ff @(posedge wr_clk_i)
  begin
    if (wr_reset_i)
    begin
      wr_bin_r       <= '0;
      wr_gray_r      <= '0;
      rd_gray_meta_r <= '0;
      rd_gray_sync_r <= '0;
    end
    else
    begin
      rd_gray_meta_r <= rd_gray_r;
      rd_gray_sync_r <= rd_gray_meta_r;
      if (wr_push)
      begin
        wr_bin_r  <= wr_bin_next;
        wr_gray_r <= bin_to_gray(wr_bin_next);
      end
    end
  end

  always_ff @(posedge wr_clk_i)
  begin
    if (wr_push)
      mem_r[wr_bin_r[fifo_lg_depth-1:0]] <= wr_data_i;
  end

  assign rd_valid_o  = (rd_gray_r != wr_gray_sync_r);
  assign rd_data_o   = flit_t'(mem_r[rd_bin_r[fifo_lg_depth-1:0]]);
  assign rd_pop      = rd_deq_i & rd_valid_o;
  assign rd_bin_next = rd_bin_r + 1'b1;

  always_ff @(posedge rd_clk_i)
  begin
    if (rd_reset_i)
    begin
      rd_bin_r       <= '0;
      rd_gray_r      <= '0;
      wr_gray_meta_r <= '0;
      wr_gray_sync_r <= '0;
    end
    else
    begin
      wr_gray_meta_r <= wr_gray_r;
      wr_gray_sync_r <= wr_gray_meta_r;
      if (rd_pop)
      begin
        rd_bin_r  <= rd_bin_next;
        rd_gray_r <= bin_to_gray(rd_bin_next);
      end
    end
  end

endmodule

//--- source/flit_sequence_gen.sv
//****************************************************************************
// Flit sequence generator
// Channel c of flit k holds k plus c, advancing once per accepted flit
//****************************************************************************

module flit_sequence_gen
  (input  logic                  node_clk_i
  ,input  logic                  node_reset_i
  ,input  logic                  step_i
  ,output link_test_pkg::flit_t  flit_o
  );

  import link_test_pkg::*;

  // Only the low channel bits of the index matter
  logic [channel_width-1:0] index_r;

  always_ff @(posedge node_clk_i)
  begin
    if (node_reset_i)
      index_r <= '0;
    else if (step_i)
      index_r <= index_r + 1'b1;
  end

  always_comb
  begin
    for (int c = 0; c < num_channels; c++)
      flit_o.channel[c] = index_r + channel_width'(c);
  end

endmodule

//--- source/link_endpoint.sv
//****************************************************************************
// Link endpoint
// Crosses a node's ready/valid streams to and from the link clock
//****************************************************************************

module link_endpoint
  (input  logic                  node_clk_i
  ,input  logic                  node_reset_i
  ,input  logic                  link_clk_i
  ,input  logic                  link_reset_i
  ,input  logic                  tx_valid_i
  ,input  link_test_pkg::flit_t  tx_data_i
  ,output logic                  tx_ready_o
  ,output logic                  rx_valid_o
  ,output link_test_pkg::flit_t  rx_data_o
  ,input  logic                  rx_ready_i
  ,input  link_test_pkg::link_s  link_i
  ,output link_test_pkg::link_s  link_o
  );

  import link_test_pkg::*;

  logic tx_full;
  logic rx_full;

  assign tx_ready_o       = ~tx_full;
  // Advertise room in our receive FIFO to the far side
  assign link_o.ready_rev = ~rx_full;

  async_link_fifo tx_fifo
    (.wr_clk_i  (node_clk_i)
    ,.wr_reset_i(node_reset_i)
    ,.wr_en_i   (tx_valid_i & ~tx_full)
    ,.wr_data_i (tx_data_i)
    ,.wr_full_o (tx_full)
    ,.rd_clk_i  (link_clk_i)
    ,.rd_reset_i(link_reset_i)
    ,.rd_deq_i  (link_i.ready_rev)
    ,.rd_data_o (link_o.data)
    ,.rd_valid_o(link_o.valid)
    );

  async_link_fifo rx_fifo
    (.wr_clk_i  (link_clk_i)
    ,.wr_reset_i(link_reset_i)
    ,.wr_en_i   (link_i.valid & ~rx_full)
    ,.wr_data_i (link_i.data)
    ,.wr_full_o (rx_full)
    ,.rd_clk_i  (node_clk_i)
    ,.rd_reset_i(node_reset_i)
    ,.rd_deq_i  (rx_ready_i)
    ,.rd_data_o (rx_data_o)
    ,.rd_valid_o(rx_valid_o)
    );

endmodule

//--- source/master_test_node.sv
//****************************************************************************
// Master test node
// Sends the flit sequence, checks the looped-back flits and counts both ways
//****************************************************************************

module master_test_node
  (input  logic                                  node_clk_i
  ,input  logic                                  node_reset_i
  ,input  logic                                  node_en_i
  ,output logic                                  error_o
  ,output logic [link_test_pkg::count_width-1:0] sent_o
  ,output logic [link_test_pkg::count_width-1:0] received_o
  ,output logic                                  tx_valid_o
  ,output link_test_pkg::flit_t                  tx_data_o
  ,input  logic                                  tx_ready_i
  ,input  logic                                  rx_valid_i
  ,input  link_test_pkg::flit_t                  rx_data_i
  ,output logic                                  rx_ready_o
  );

  import link_test_pkg::*;

  flit_t gen_flit;
  flit_t check_flit;
  flit_t resp_data;
  logic  req_ready;
  logic  req_accept;
  logic  resp_valid;

  assign req_accept = node_en_i & req_ready;

  two_slot_fifo req_fifo
    (.node_clk_i  (node_clk_i)
    ,.node_reset_i(node_reset_i)
    ,.in_valid_i  (node_en_i)
    ,.in_data_i   (gen_flit)
    ,.in_ready_o  (req_ready)
    ,.out_valid_o (tx_valid_o)
    ,.out_data_o  (tx_data_o)
    ,.out_ready_i (tx_ready_i)
    );

  // Responses are always consumed
  two_slot_fifo resp_fifo
    (.node_clk_i  (node_clk_i)
    ,.node_reset_i(node_reset_i)
    ,.in_valid_i  (rx_valid_i)
    ,.in_data_i   (rx_data_i)
    ,.in_ready_o  (rx_ready_o)
    ,.out_valid_o (resp_valid)
    ,.out_data_o  (resp_data)
    ,.out_ready_i (1'b1)
    );

  flit_sequence_gen gen
    (.node_clk_i  (node_clk_i)
    ,.node_reset_i(node_reset_i)
    ,.step_i      (req_accept)
    ,.flit_o      (gen_flit)
    );

  flit_sequence_gen check_gen
    (.node_clk_i  (node_clk_i)
    ,.node_reset_i(node_reset_i)
    ,.step_i      (resp_valid)
    ,.flit_o      (check_flit)
    );

  always_ff @(posedge node_clk_i)
  begin
    if (node_reset_i)
    begin
      error_o    <= 1'b0;
      sent_o     <= '0;
      received_o <= '0;
    end
    else
    begin
      if (req_accept)
        sent_o <= sent_o + 1'b1;
      if (resp_valid)
        received_o <= received_o + 1'b1;
      // Sticky until reset
      if (resp_valid && (resp_data != check_flit))
        error_o <= 1'b1;
    end
  end

endmodule

//--- source/client_test_node.sv
//****************************************************************************
// Client test node
// Loops every received flit back in order
//****************************************************************************

module client_test_node
  (input  logic                  node_clk_i
  ,input  logic                  node_reset_i
  ,input  logic                  rx_valid_i
  ,input  link_test_pkg::flit_t  rx_data_i
  ,output logic                  rx_ready_o
  ,output logic                  tx_valid_o
  ,output link_test_pkg::flit_t  tx_data_o
  ,input  logic                  tx_ready_i
  );

  import link_test_pkg::*;

  logic  loop_valid;
  flit_t loop_data;
  logic  loop_ready;

  two_slot_fifo req_in_fifo
    (.node_clk_i  (node_clk_i)
    ,.node_reset_i(node_reset_i)
    ,.in_valid_i  (rx_valid_i)
    ,.in_data_i   (rx_data_i)
    ,.in_ready_o  (rx_ready_o)
    ,.out_valid_o (loop_valid)
    ,.out_data_o  (loop_data)
    ,.out_ready_i (loop_ready)
    );

  two_slot_fifo resp_out_fifo
    (.node_clk_i  (node_clk_i)
    ,.node_reset_i(node_reset_i)
    ,.in_valid_i  (loop_valid)
    ,.in_data_i   (loop_data)
    ,.in_ready_o  (loop_ready)
    ,.out_valid_o (tx_valid_o)
    ,.out_data_o  (tx_data_o)
    ,.out_ready_i (tx_ready_i)
    );

endmodule

//--- source/link_test_top.sv
//****************************************************************************
// Link test top
// Master and client test nodes joined over a clock-crossing link
//****************************************************************************

module link_test_top
  (input  logic                                  node_clk_i
  ,input  logic                                  node_reset_i
  ,input  logic                                  link_clk_i
  ,input  logic                                  link_reset_i
  ,input  logic                                  node_en_i
  ,output logic                                  error_o
  ,output logic [link_test_pkg::count_width-1:0] sent_o
  ,output logic [link_test_pkg::count_width-1:0] received_o
  );

  import link_test_pkg::*;

  // Master side streams
  logic  m_tx_valid, m_tx_ready, m_rx_valid, m_rx_ready;
  flit_t m_tx_data, m_rx_data;

  // Client side streams
  logic  c_tx_valid, c_tx_ready, c_rx_valid, c_rx_ready;
  flit_t c_tx_data, c_rx_data;

  link_s link_m2c;
  link_s link_c2m;

  master_test_node master_inst
    (.node_clk_i(node_clk_i), .node_reset_i(node_reset_i), .node_en_i(node_en_i)
    ,.error_o(error_o), .sent_o(sent_o), .received_o(received_o)
    ,.tx_valid_o(m_tx_valid), .tx_data_o(m_tx_data), .tx_ready_i(m_tx_ready)
    ,.rx_valid_i(m_rx_valid), .rx_data_i(m_rx_data), .rx_ready_o(m_rx_ready)
    );

  link_endpoint master_endpoint
    (.node_clk_i(node_clk_i), .node_reset_i(node_reset_i)
    ,.link_clk_i(link_clk_i), .link_reset_i(link_reset_i)
    ,.tx_valid_i(m_tx_valid), .tx_data_i(m_tx_data), .tx_ready_o(m_tx_ready)
    ,.rx_valid_o(m_rx_valid), .rx_data_o(m_rx_data), .rx_ready_i(m_rx_ready)
    ,.link_i(link_c2m), .link_o(link_m2c)
    );

  link_endpoint client_endpoint
    (.node_clk_i(node_clk_i), .node_reset_i(node_reset_i)
    ,.link_clk_i(link_clk_i), .link_reset_i(link_reset_i)
    ,.tx_valid_i(c_tx_valid), .tx_data_i(c_tx_data), .tx_ready_o(c_tx_ready)
    ,.rx_valid_o(c_rx_valid), .rx_data_o(c_rx_data), .rx_ready_i(c_rx_ready)
    ,.link_i(link_m2c), .link_o(link_c2m)
    );

  client_test_node client_inst
    (.node_clk_i(node_clk_i), .node_reset_i(node_reset_i)
    ,.rx_valid_i(c_rx_valid), .rx_data_i(c_rx_data), .rx_ready_o(c_rx_ready)
    ,.tx_valid_o(c_tx_valid), .tx_data_o(c_tx_data), .tx_ready_i(c_tx_ready)
    );

endmodule

//--- dv/link_test_tb.sv
//****************************************************************************
// Link test testbench
// Runs enable bursts at several link clock rates and checks the counters
//****************************************************************************

module link_test_tb;

  import link_test_pkg::*;

  localparam int node_half = 50;
  localparam string pattern_path = "dv/link_test_patterns.txt";

  logic                   node_clk   = 1'b0;
  logic                   link_clk   = 1'b0;
  logic                   node_reset = 1'b1;
  logic                   link_reset = 1'b1;
  logic                   node_en    = 1'b0;
  logic                   error;
  logic [count_width-1:0] sent;
  logic [count_width-1:0] received;

  int link_half     = node_half;
  int timeout_limit = 1000;
  int cycle_count   = 0;
  int pass_count    = 0;
  int fail_count    = 0;
  int en_cycles_q[$];
  int idle_cycles_q[$];
  int half_period_q[$];

  link_test_top link_test_top_inst
    (.node_clk_i  (node_clk)
    ,.node_reset_i(node_reset)
    ,.link_clk_i  (link_clk)
    ,.link_reset_i(link_reset)
    ,.node_en_i   (node_en)
    ,.error_o     (error)
    ,.sent_o      (sent)
    ,.received_o  (received)
    );

  always
  begin
    #(node_half) node_clk = ~node_clk;
  end

  // Half period follows the current test
  always
  begin
    #(link_half) link_clk = ~link_clk;
  end

  always @(posedge node_clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_limit)
    begin
      $display("Run timed out after %0d node cycles", cycle_count);
      $display("test failed");
      $finish;
    end
  end

  task automatic load_patterns();
    int                 fd;
    int                 code;
    int                 en_c;
    int                 idle_c;
    int                 half_c;
    logic [8*128-1:0]   line;
    fd = $fopen(pattern_path, "r");
    if (fd == 0)
    begin
      $display("Could not open the pattern file %s", pattern_path);
      return;
    end
    while (!$feof(fd))
    begin
      code = $fscanf(fd, "%d %d %d", en_c, idle_c, half_c);
      if (code == 3 && half_c > 0)
      begin
        en_cycles_q.push_back(en_c);
        idle_cycles_q.push_back(idle_c);
        half_period_q.push_back(half_c);
        timeout_limit += 4 * (en_c + idle_c);
      end
      else if ($fgets(line, fd) == 0)
        break;
    end
    $fclose(fd);
  endtask

  task automatic check_reset();
    int errors;
    errors = 0;
    if (sent !== '0)
    begin
      $display("FAILED t=%0t sent_o expected 0 actual %0d", $time, sent);
      errors++;
    end
    if (received !== '0)
    begin
      $display("FAILED t=%0t received_o expected 0 actual %0d", $time, received);
      errors++;
    end
    if (error !== 1'b0)
    begin
      $display("FAILED t=%0t error_o expected 0 actual %b", $time, error);
      errors++;
    end
    $display("Reset check: %0d errors", errors);
    if (errors == 0)
      pass_count++;
    else
      fail_count++;
  endtask

  task automatic run_test(input int idx);
    int                     en_c;
    int                     idle_c;
    int                     delta;
    int                     waited;
    int                     errors;
    logic [count_width-1:0] sent_start;
    logic [count_width-1:0] sent_end;
    en_c   = en_cycles_q[idx];
    idle_c = idle_cycles_q[idx];
    errors = 0;
    @(negedge node_clk);
    sent_start = sent;
    link_half  = half_period_q[idx];
    @(posedge node_clk);
    node_en <= 1'b1;
    repeat (en_c) @(posedge node_clk);
    node_en <= 1'b0;
    @(negedge node_clk);
    sent_end = sent;
    delta    = int'(sent_end - sent_start);
    if (delta < 1 || delta > en_c)
    begin
      $display("FAILED t=%0t sent_o increase expected 1 to %0d actual %0d", $time, en_c, delta);
      errors++;
    end
    // A slow link cannot take one flit per node cycle
    if (link_half > node_half && delta >= en_c)
    begin
      $display("FAILED t=%0t sent_o increase expected below %0d actual %0d",
               $time, en_c, delta);
      errors++;
    end
    waited = 0;
    while (received != sent && waited < idle_c)
    begin
      @(negedge node_clk);
      waited++;
    end
    if (received != sent)
    begin
      $display("Test %0d: the flits did not return within %0d idle cycles", idx + 1, idle_c);
      $display("FAILED t=%0t received_o expected %0d actual %0d", $time, sent, received);
      errors++;
    end
    if (sent != sent_end)
    begin
      $display("FAILED t=%0t sent_o expected %0d actual %0d", $time, sent_end, sent);
      errors++;
    end
    if (error !== 1'b0)
    begin
      $display("FAILED t=%0t error_o expected 0 actual %b", $time, error);
      errors++;
    end
    $display("Test %0d: half period %0d, enabled %0d, sent %0d, returned after %0d cycles, %0d %s",
             idx + 1, link_half, en_c, delta, waited, errors, "errors");
    if (errors == 0)
      pass_count++;
    else
      fail_count++;
  endtask

  initial
  begin
    load_patterns();
    if (half_period_q.size() > 0)
      link_half = half_period_q[0];
    repeat (10) @(posedge node_clk);
    node_reset <= 1'b0;
    link_reset <= 1'b0;
    @(negedge node_clk);
    check_reset();
    for (int i = 0; i < en_cycles_q.size(); i++)
      run_test(i);
    if (en_cycles_q.size() == 0)
    begin
      $display("No tests were read from the pattern file");
      fail_count++;
    end
    $display("Checks done: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- dv/link_test_patterns.txt
# Columns: enable cycles, idle cycles, link clock half period
# Half period 30 is a fast link, 50 matches the node clock, 150 is slow
30 150 30
1 100 50
64 200 50
200 600 150
40 200 30
120 400 30
300 800 150
16 150 50

//--- filelist.f
source/link_test_pkg.sv
source/two_slot_fifo.sv
source/async_link_fifo.sv
source/flit_sequence_gen.sv
source/link_endpoint.sv
source/master_test_node.sv
source/client_test_node.sv
source/link_test_top.sv
dv/link_test_tb.sv

//--- Bender.yml
package:
  name: link_test

sources:
  - source/link_test_pkg.sv
  - source/two_slot_fifo.sv
  - source/async_link_fifo.sv
  - source/flit_sequence_gen.sv
  - source/link_endpoint.sv
  - source/master_test_node.sv
  - source/client_test_node.sv
  - source/link_test_top.sv
  - target: test
    files:
      - dv/link_test_tb.sv
